//--- list.f
+incdir+.
isaPkg.sv
pipePkg.sv
pipelineRegisters.sv
regFile.sv
controlUnit.sv
hazardUnit.sv
aluUnit.sv
dataBusMaster.sv
mipsCore.sv
tbMipsCore.sv

//--- Makefile
TOP = tbMipsCore

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f list.f --top-module mipsCore

sim:
	verilator --binary --timing -f list.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "Testbench passed"

clean:
	rm -rf obj_dir

//--- tbMipsCore.sv
// Loads and stores use r0 as base within 16 data words. Branches only skip forward
`timescale 1ns/1ps
`include "mipsCore_settings.svh"

module tbMipsCore;
	import isaPkg::*;

	localparam int progLen = 60;
	localparam int randomLen = 52;
	localparam int runLimit = 4000;

	logic sysclk;
	logic reset;
	logic [`DATA_WIDTH-1:0] fetchAddr;
	instrWordT instr;
	logic wbCyc, wbStb, wbWe, wbAck;
	logic [`DBUS_ADDR_WIDTH-1:0] wbAdr;
	logic [`DATA_WIDTH-1:0] wbDatOut, wbDatIn;

	instrWordT imem [256];
	logic [`DATA_WIDTH-1:0] initMem [16];
	logic [`DATA_WIDTH-1:0] dmem [16];
	int waitLeft = 2;

	// Expected bus accesses in program order
	bit opWrite [$];
	logic [`DBUS_ADDR_WIDTH-1:0] opAddr [$];
	logic [`DATA_WIDTH-1:0] opData [$];

	int errorCount = 0;
	int testsFailed = 0;
	int writeErrors = 0;
	int readErrors = 0;
	int writesSeen = 0;
	int readsSeen = 0;
	int extraCycles = 0;
	int dependentPairs = 0;
	int loadUsePairs = 0;
	int takenBranches = 0;
	int notTakenBranches = 0;

	mipsCore dut (
		.sysclk(sysclk), .reset(reset),
		.fetchAddr(fetchAddr), .instr(instr),
		.wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe), .wbAdr(wbAdr),
		.wbDatOut(wbDatOut), .wbDatIn(wbDatIn), .wbAck(wbAck)
	);

	always #2 sysclk = ~sysclk;

	task automatic expectAddr(input string name, input logic [`DBUS_ADDR_WIDTH-1:0] got,
			input logic [`DBUS_ADDR_WIDTH-1:0] exp);
		if (got !== exp) begin
			$display("Error: %s = %h, expected %h at %0t", name, got, exp, $time);
			errorCount++;
		end
	endtask

	task automatic compareWord(input string name, input logic [`DATA_WIDTH-1:0] got,
			input logic [`DATA_WIDTH-1:0] exp);
		if (got !== exp) begin
			$display("Error: %s = %h, expected %h at %0t", name, got, exp, $time);
			errorCount++;
		end
	endtask

	task automatic matchFlag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("Error: %s = %h, expected %h at %0t", name, got, exp, $time);
			errorCount++;
		end
	endtask

	task automatic inspectResetState();
		matchFlag("wbCyc", wbCyc, 1'b0);
		matchFlag("wbStb", wbStb, 1'b0);
		matchFlag("wbWe", wbWe, 1'b0);
		compareWord("fetchAddr", fetchAddr, `RESET_PC);
	endtask

	task automatic reportTest(input int num, input string detail, input bit ok);
		$display("Test %0d %s: %s", num, detail, ok ? "ok" : "FAIL");
		if (!ok) begin
			testsFailed++;
		end
	endtask

	function automatic instrWordT rTypeWord(functT fn, logic [4:0] rs, logic [4:0] rt,
			logic [4:0] rd);
		instrWordT w;
		w = '0;
		w.r.opcode = opRType;
		w.r.rs = rs;
		w.r.rt = rt;
		w.r.rd = rd;
		w.r.funct = fn;
		return w;
	endfunction

	function automatic instrWordT iTypeWord(opcodeT op, logic [4:0] rs, logic [4:0] rt,
			logic [15:0] imm);
		instrWordT w;
		w.i.opcode = op;
		w.i.rs = rs;
		w.i.rt = rt;
		w.i.imm = imm;
		return w;
	endfunction

	function automatic functT pickFunct();
		case ($urandom % 5)
			0: return fnAddu;
			1: return fnSubu;
			2: return fnAnd;
			3: return fnOr;
			default: return fnSlt;
		endcase
	endfunction

	// Random body, then stores of r1..r7 and a branch to itself
	task automatic buildProgram();
		logic [4:0] lastDest, rs, rt, rd;
		int kind, skip;
		lastDest = 5'd1;
		for (int k = 0; k < 256; k++) begin
			imem[k] = '0;
		end
		for (int k = 0; k < randomLen; k++) begin
			kind = $urandom % 10;
			// Half the time read the previous result
			rs = ($urandom % 2 == 0) ? lastDest : 5'($urandom % 8);
			rt = 5'($urandom % 8);
			rd = 5'(1 + $urandom % 7);
			if (kind < 4) begin
				imem[k] = rTypeWord(pickFunct(), rs, rt, rd);
				lastDest = rd;
			end else if (kind < 6) begin
				imem[k] = iTypeWord(opAddiu, rs, rd, 16'($urandom % 64) - 16'd32);
				lastDest = rd;
			end else if (kind == 6) begin
				imem[k] = iTypeWord(opLw, 5'd0, rd, 16'(4 * ($urandom % 16)));
				lastDest = rd;
			end else if (kind == 7) begin
				imem[k] = iTypeWord(opSw, 5'd0, rs, 16'(4 * ($urandom % 16)));
			end else begin
				skip = 1 + $urandom % 3;
				if (k + 1 + skip > randomLen) begin
					skip = randomLen - k - 1;
				end
				imem[k] = iTypeWord(opBeq, rs, ($urandom % 3 == 0) ? rs : rt, 16'(skip));
			end
		end
		for (int k = 0; k < 7; k++) begin
			imem[randomLen + k] = iTypeWord(opSw, 5'd0, 5'(k + 1), 16'(4 * (k + 1)));
		end
		imem[progLen - 1] = iTypeWord(opBeq, 5'd0, 5'd0, 16'hffff);
	endtask

	// Plain ISA interpreter, one instruction per step
	task automatic runModel();
		logic [`DATA_WIDTH-1:0] modelRegs [32];
		logic [`DATA_WIDTH-1:0] mem [16];
		logic [`DATA_WIDTH-1:0] a, b, imm, addr;
		logic [4:0] prevDest;
		logic prevLoad, usesRt;
		instrWordT w;
		int pc, steps;
		for (int i = 0; i < 32; i++) begin
			modelRegs[i] = '0;
		end
		for (int i = 0; i < 16; i++) begin
			mem[i] = initMem[i];
		end
		pc = 0;
		steps = 0;
		prevDest = 5'd0;
		prevLoad = 1'b0;
		while (pc != progLen - 1 && steps < 500) begin
			w = imem[pc];
			a = modelRegs[w.r.rs];
			b = modelRegs[w.r.rt];
			imm = {{16{w.i.imm[15]}}, w.i.imm};
			usesRt = w.i.opcode == opRType || w.i.opcode == opSw || w.i.opcode == opBeq;
			if (prevDest != 5'd0 && (w.r.rs == prevDest || (usesRt && w.r.rt == prevDest))) begin
				if (prevLoad) begin
					loadUsePairs++;
				end else begin
					dependentPairs++;
				end
			end
			prevDest = 5'd0;
			prevLoad = 1'b0;
			pc++;
			case (w.i.opcode)
				opRType: begin
					case (w.r.funct)
						fnAddu: modelRegs[w.r.rd] = a + b;
						fnSubu: modelRegs[w.r.rd] = a - b;
						fnAnd:  modelRegs[w.r.rd] = a & b;
						fnOr:   modelRegs[w.r.rd] = a | b;
						fnSlt:  modelRegs[w.r.rd] = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
						default: ;
					endcase
					prevDest = w.r.rd;
				end
				opAddiu: begin
					modelRegs[w.i.rt] = a + imm;
					prevDest = w.i.rt;
				end
				opLw: begin
					addr = a + imm;
					modelRegs[w.i.rt] = mem[addr[5:2]];
					opWrite.push_back(1'b0);
					opAddr.push_back(addr[`DBUS_ADDR_WIDTH+1:2]);
					opData.push_back('0);
					prevDest = w.i.rt;
					prevLoad = 1'b1;
				end
				opSw: begin
					addr = a + imm;
					mem[addr[5:2]] = b;
					opWrite.push_back(1'b1);
					opAddr.push_back(addr[`DBUS_ADDR_WIDTH+1:2]);
					opData.push_back(b);
				end
				opBeq: begin
					if (a == b) begin
						pc = pc + int'($signed(imm));
						takenBranches++;
					end else begin
						notTakenBranches++;
					end
				end
				default: ;
			endcase
			modelRegs[0] = '0;
			steps++;
		end
	endtask

	// Instruction memory with one edge of latency
	always @(posedge sysclk) begin
		instr <= imem[fetchAddr[9:2]];
	end

	// Wishbone slave, 0 to 3 wait cycles before wbAck
	always @(posedge sysclk) begin
		if (!reset) begin
			for (int i = 0; i < 16; i++) begin
				dmem[i] <= initMem[i];
			end
			wbAck <= 1'b0;
		end else if (wbAck) begin
			wbAck <= 1'b0;
			waitLeft <= $urandom % 4;
		end else if (wbCyc && wbStb) begin
			if (waitLeft == 0) begin
				wbAck <= 1'b1;
				if (wbWe) begin
					dmem[wbAdr[3:0]] <= wbDatOut;
				end else begin
					wbDatIn <= dmem[wbAdr[3:0]];
				end
			end else begin
				waitLeft <= waitLeft - 1;
			end
		end
	end

	// Bus monitor, one expected access per acknowledged cycle
	always @(posedge sysclk) begin
		int errorsBefore;
		if (reset && wbCyc && opWrite.size() == 0) begin
			extraCycles++;
			if (extraCycles == 1) begin
				$display("Unexpected bus cycle at wbAdr %h after the last expected access", wbAdr);
			end
		end else if (reset && wbCyc && wbStb && wbAck) begin
			errorsBefore = errorCount;
			matchFlag("wbWe", wbWe, opWrite[0]);
			expectAddr("wbAdr", wbAdr, opAddr[0]);
			if (opWrite[0]) begin
				compareWord("wbDatOut", wbDatOut, opData[0]);
				writeErrors += errorCount - errorsBefore;
				writesSeen++;
			end else begin
				readErrors += errorCount - errorsBefore;
				readsSeen++;
			end
			void'(opWrite.pop_front());
			void'(opAddr.pop_front());
			void'(opData.pop_front());
		end
	end

	initial begin
		int cycles, expWrites, expReads;
		bit done;
		sysclk = 1'b0;
		reset = 1'b0;
		instr = '0;
		wbAck = 1'b0;
		wbDatIn = '0;
		void'($urandom(32'h003e05d0));
		for (int i = 0; i < 16; i++) begin
			initMem[i] = $urandom;
		end
		buildProgram();
		runModel();
		expWrites = 0;
		foreach (opWrite[i]) begin
			if (opWrite[i]) begin
				expWrites++;
			end
		end
		expReads = opWrite.size() - expWrites;

		for (int c = 0; c < 3; c++) begin
			@(negedge sysclk);
			inspectResetState();
		end
		@(posedge sysclk);
		reset <= 1'b1;
		// First cycle out of reset, still fetching RESET_PC
		@(negedge sysclk);
		inspectResetState();
		reportTest(1, "reset state", errorCount == 0);

		cycles = 0;
		while (opWrite.size() != 0 && cycles < runLimit) begin
			@(negedge sysclk);
			cycles++;
		end
		done = opWrite.size() == 0;
		if (!done) begin
			$display("Timeout: %0d expected bus accesses missing after %0d cycles",
				opWrite.size(), cycles);
		end
		// Watch for stray cycles while the core spins on the last branch
		for (int c = 0; c < 40; c++) begin
			@(negedge sysclk);
		end

		reportTest(2, $sformatf("bus writes %0d of %0d", writesSeen, expWrites),
			done && writeErrors == 0 && writesSeen == expWrites);
		reportTest(3, $sformatf("forwarding over %0d dependent pairs", dependentPairs),
			done && writeErrors == 0 && readErrors == 0);
		reportTest(4, $sformatf("bus reads %0d of %0d, %0d load-use pairs", readsSeen,
			expReads, loadUsePairs), done && readErrors == 0 && readsSeen == expReads);
		reportTest(5, $sformatf("branches %0d taken, %0d not taken", takenBranches,
			notTakenBranches), done && writeErrors == 0 && extraCycles == 0);
		reportTest(6, $sformatf("completion in %0d cycles, %0d stray bus cycles", cycles,
			extraCycles), done && extraCycles == 0);

		$display("Summary: 6 tests, %0d failed, %0d mismatches", testsFailed, errorCount);
		if (testsFailed == 0 && errorCount == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end
endmodule

//--- mipsCore.sv
// Five-stage MIPS subset core without jumps or exceptions. instr arrives one edge after fetchAddr
`timescale 1ns/1ps
`include "mipsCore_settings.svh"

module mipsCore (
	input  logic                        sysclk,
	input  logic                        reset,
	output logic [`DATA_WIDTH-1:0]      fetchAddr,
	input  isaPkg::instrWordT           instr,
	output logic                        wbCyc,
	output logic                        wbStb,
	output logic                        wbWe,
	output logic [`DBUS_ADDR_WIDTH-1:0] wbAdr,
	output logic [`DATA_WIDTH-1:0]      wbDatOut,
	input  logic [`DATA_WIDTH-1:0]      wbDatIn,
	input  logic                        wbAck
);
	import isaPkg::*;
	import pipePkg::*;

	logic [`DATA_WIDTH-1:0] pcReg, nextPc, branchTarget;
	logic fetchValid, pcHold, branchGo;
	logic busStall, loadStall, branchFlush, branchTaken;
	logic [1:0] fwdA, fwdB;

	instrWordT ifIdInstr;
	logic [`DATA_WIDTH-1:0] ifIdPc, regA, regB, immId;
	exCtrlT exCtrlId, exCtrlEx;
	memCtrlT memCtrlId, memCtrlEx, memCtrlMem;
	wbCtrlT wbCtrlId, wbCtrlEx, wbCtrlMem, wbCtrlWb;

	logic [4:0] exRs, exRt, exRd, exDest, memDest, wbDest;
	logic [`DATA_WIDTH-1:0] exDataA, exDataB, exImm, exPc;
	logic [`DATA_WIDTH-1:0] opA, fwdValB, opB, aluResult;
	logic aluEqual;

	logic [`DATA_WIDTH-1:0] memAluResult, memStoreData, memReadData;
	logic [`DATA_WIDTH-1:0] wbAluResult, wbReadData, wbValue;

	// Fetch. First cycle after reset only launches the read of RESET_PC
	always_ff @(posedge sysclk or negedge reset) begin
		if (!reset) begin
			pcReg <= `RESET_PC;
			fetchValid <= 1'b0;
		end else begin
			pcReg <= nextPc;
			fetchValid <= 1'b1;
		end
	end

	// A branch waits in EX while the bus is busy
	assign branchGo = branchFlush && !busStall;
	assign pcHold = busStall || loadStall || !fetchValid;

	always_comb begin
		if (branchGo) begin
			nextPc = branchTarget;
		end else if (pcHold) begin
			nextPc = pcReg;
		end else begin
			nextPc = pcReg + 'd4;
		end
	end

	assign fetchAddr = nextPc;

	ifIdRegister ifId (
		.sysclk(sysclk), .reset(reset),
		.hold(busStall || loadStall),
		.flush(!busStall && (branchFlush || !fetchValid)),
		.pcIn(pcReg), .instrIn(instr),
		.pcOut(ifIdPc), .instrOut(ifIdInstr)
	);

	// Decode
	regFile regs (
		.sysclk(sysclk), .reset(reset),
		.readAddrA(ifIdInstr.r.rs), .readAddrB(ifIdInstr.r.rt),
		.writeAddr(wbDest), .writeEn(wbCtrlWb.regWrite), .writeData(wbValue),
		.readDataA(regA), .readDataB(regB)
	);

	controlUnit ctrl (
		.instr(ifIdInstr),
		.exCtrl(exCtrlId), .memCtrl(memCtrlId), .wbCtrl(wbCtrlId),
		.imm(immId)
	);

	hazardUnit hazards (
		.idRs(ifIdInstr.r.rs), .idRt(ifIdInstr.r.rt),
		.exRs(exRs), .exRt(exRt),
		.memDest(memDest), .wbDest(wbDest), .exDest(exDest),
		.exMemRead(memCtrlEx.memRead),
		.memRegWrite(wbCtrlMem.regWrite), .wbRegWrite(wbCtrlWb.regWrite),
		.branchTaken(branchTaken),
		.fwdA(fwdA), .fwdB(fwdB),
		.loadStall(loadStall), .branchFlush(branchFlush)
	);

	idExRegister idEx (
		.sysclk(sysclk), .reset(reset),
		.hold(busStall),
		.flush(!busStall && (branchFlush || loadStall)),
		.exCtrlIn(exCtrlId), .memCtrlIn(memCtrlId), .wbCtrlIn(wbCtrlId),
		.rsIn(ifIdInstr.r.rs), .rtIn(ifIdInstr.r.rt), .rdIn(ifIdInstr.r.rd),
		.dataAIn(regA), .dataBIn(regB), .immIn(immId), .pcIn(ifIdPc),
		.exCtrlOut(exCtrlEx), .memCtrlOut(memCtrlEx), .wbCtrlOut(wbCtrlEx),
		.rsOut(exRs), .rtOut(exRt), .rdOut(exRd),
		.dataAOut(exDataA), .dataBOut(exDataB), .immOut(exImm), .pcOut(exPc)
	);

	// Execute
	always_comb begin
		case (fwdA)
			2'd2:    opA = memAluResult;
			2'd1:    opA = wbValue;
			default: opA = exDataA;
		endcase
		case (fwdB)
			2'd2:    fwdValB = memAluResult;
			2'd1:    fwdValB = wbValue;
			default: fwdValB = exDataB;
		endcase
	end

	assign opB = exCtrlEx.immSel ? exImm : fwdValB;
	assign exDest = exCtrlEx.destRd ? exRd : exRt;

	aluUnit alu (
		.aluOp(exCtrlEx.aluOp), .opA(opA), .opB(opB),
		.result(aluResult), .equal(aluEqual)
	);

	assign branchTaken = exCtrlEx.branch && aluEqual;
	assign branchTarget = exPc + 'd4 + {exImm[`DATA_WIDTH-3:0], 2'b00};

	exMemRegister exMem (
		.sysclk(sysclk), .reset(reset), .hold(busStall),
		.memCtrlIn(memCtrlEx), .wbCtrlIn(wbCtrlEx),
		.aluResultIn(aluResult), .storeDataIn(fwdValB), .destIn(exDest),
		.memCtrlOut(memCtrlMem), .wbCtrlOut(wbCtrlMem),
		.aluResultOut(memAluResult), .storeDataOut(memStoreData), .destOut(memDest)
	);

	// Memory
	dataBusMaster dbus (
		.sysclk(sysclk), .reset(reset),
		.memCtrl(memCtrlMem), .addr(memAluResult), .storeData(memStoreData),
		.readData(memReadData), .busStall(busStall),
		.wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe), .wbAdr(wbAdr),
		.wbDatOut(wbDatOut), .wbDatIn(wbDatIn), .wbAck(wbAck)
	);

	memWbRegister memWb (
		.sysclk(sysclk), .reset(reset), .hold(busStall),
		.wbCtrlIn(wbCtrlMem), .aluResultIn(memAluResult),
		.readDataIn(memReadData), .destIn(memDest),
		.wbCtrlOut(wbCtrlWb), .aluResultOut(wbAluResult),
		.readDataOut(wbReadData), .destOut(wbDest)
	);

	// Writeback
	assign wbValue = wbCtrlWb.memToReg ? wbReadData : wbAluResult;
endmodule

//--- dataBusMaster.sv
// Wishbone classic master for word loads and stores. It holds the pipeline until wbAck
`timescale 1ns/1ps
`include "mipsCore_settings.svh"

module dataBusMaster (
	input  logic                       sysclk,
	input  logic                       reset,
	input  pipePkg::memCtrlT           memCtrl,
	input  logic [`DATA_WIDTH-1:0]     addr,
	input  logic [`DATA_WIDTH-1:0]     storeData,
	output logic [`DATA_WIDTH-1:0]     readData,
	output logic                       busStall,
	output logic                       wbCyc,
	output logic                       wbStb,
	output logic                       wbWe,
	output logic [`DBUS_ADDR_WIDTH-1:0] wbAdr,
	output logic [`DATA_WIDTH-1:0]     wbDatOut,
	input  logic [`DATA_WIDTH-1:0]     wbDatIn,
	input  logic                       wbAck
);
	typedef enum logic {stIdle, stWaiting} stateT;

	stateT state;
	logic access;

	assign access = memCtrl.memRead | memCtrl.memWrite;

	// Waiting means a cycle is open and not yet acknowledged
	always_ff @(posedge sysclk or negedge reset) begin
		if (!reset) begin
			state <= stIdle;
		end else begin
			case (state)
				stIdle: if (access && !wbAck) state <= stWaiting;
				stWaiting: if (wbAck) state <= stIdle;
				default: state <= stIdle;
			endcase
		end
	end

	// EX/MEM holds, so address and data stay stable until wbAck
	assign wbCyc = access || state == stWaiting;
	assign wbStb = wbCyc;
	assign wbWe = wbCyc && memCtrl.memWrite;
	assign wbAdr = addr[`DBUS_ADDR_WIDTH+1:2];
	assign wbDatOut = storeData;

	// MEM/WB takes the data on the wbAck edge
	assign readData = wbDatIn;
	assign busStall = wbCyc && !wbAck;
endmodule

//--- aluUnit.sv
// ALU for the core. SLT compares signed and equal feeds the BEQ decision
`timescale 1ns/1ps
`include "mipsCore_settings.svh"

module aluUnit (
	input  pipePkg::aluOpT         aluOp,
	input  logic [`DATA_WIDTH-1:0] opA,
	input  logic [`DATA_WIDTH-1:0] opB,
	output logic [`DATA_WIDTH-1:0] result,
	output logic                   equal
);
	import pipePkg::*;

	logic isLess;

	assign isLess = $signed(opA) < $signed(opB);

	always_comb begin
		case (aluOp)
			aluAdd:  result = opA + opB;
			aluSub:  result = opA - opB;
			aluAnd:  result = opA & opB;
			aluOr:   result = opA | opB;
			aluSlt:  result = {{(`DATA_WIDTH-1){1'b0}}, isLess};
			aluPass: result = opB;
			default: result = '0;
		endcase
	end

	assign equal = (opA == opB);
endmodule

//--- hazardUnit.sv
// Forwarding into EX and load-use detection. fwd codes are 2 for EX/MEM, 1 for MEM/WB, 0 for none
`timescale 1ns/1ps

module hazardUnit (
	input  logic [4:0] idRs,
	input  logic [4:0] idRt,
	input  logic [4:0] exRs,
	input  logic [4:0] exRt,
	input  logic [4:0] memDest,
	input  logic [4:0] wbDest,
	input  logic [4:0] exDest,
	input  logic       exMemRead,
	input  logic       memRegWrite,
	input  logic       wbRegWrite,
	input  logic       branchTaken,
	output logic [1:0] fwdA,
	output logic [1:0] fwdB,
	output logic       loadStall,
	output logic       branchFlush
);
	// The younger result in EX/MEM wins over MEM/WB
	always_comb begin
		fwdA = 2'd0;
		if (memRegWrite && memDest != 5'd0 && memDest == exRs) begin
			fwdA = 2'd2;
		end else if (wbRegWrite && wbDest != 5'd0 && wbDest == exRs) begin
			fwdA = 2'd1;
		end
		fwdB = 2'd0;
		if (memRegWrite && memDest != 5'd0 && memDest == exRt) begin
			fwdB = 2'd2;
		end else if (wbRegWrite && wbDest != 5'd0 && wbDest == exRt) begin
			fwdB = 2'd1;
		end
	end

	// Rt counts as a source even for I-types, which may stall needlessly
	assign loadStall = exMemRead && exDest != 5'd0 && (exDest == idRs || exDest == idRt);

	assign branchFlush = branchTaken;
endmodule

//--- controlUnit.sv
// Decoder for ADDU SUBU AND OR SLT ADDIU LW SW BEQ. Anything else becomes a bubble
`timescale 1ns/1ps
`include "mipsCore_settings.svh"

module controlUnit (
	input  isaPkg::instrWordT      instr,
	output pipePkg::exCtrlT        exCtrl,
	output pipePkg::memCtrlT       memCtrl,
	output pipePkg::wbCtrlT        wbCtrl,
	output logic [`DATA_WIDTH-1:0] imm
);
	import isaPkg::*;
	import pipePkg::*;

	assign imm = {{(`DATA_WIDTH-16){instr.i.imm[15]}}, instr.i.imm};

	always_comb begin
		exCtrl = '0;
		memCtrl = '0;
		wbCtrl = '0;
		case (instr.i.opcode)
			opRType: begin
				exCtrl.destRd = 1'b1;
				wbCtrl.regWrite = 1'b1;
				case (instr.r.funct)
					fnAddu: exCtrl.aluOp = aluAdd;
					fnSubu: exCtrl.aluOp = aluSub;
					fnAnd:  exCtrl.aluOp = aluAnd;
					fnOr:   exCtrl.aluOp = aluOr;
					fnSlt:  exCtrl.aluOp = aluSlt;
					default: begin
						// Includes the all-zero word
						exCtrl = '0;
						wbCtrl = '0;
					end
				endcase
			end
			opAddiu: begin
				exCtrl.immSel = 1'b1;
				wbCtrl.regWrite = 1'b1;
			end
			opLw: begin
				exCtrl.immSel = 1'b1;
				memCtrl.memRead = 1'b1;
				wbCtrl.regWrite = 1'b1;
				wbCtrl.memToReg = 1'b1;
			end
			opSw: begin
				exCtrl.immSel = 1'b1;
				memCtrl.memWrite = 1'b1;
			end
			opBeq: begin
				// Compare rs with rt, no writeback
				exCtrl.aluOp = aluSub;
				exCtrl.branch = 1'b1;
			end
			default: ;
		endcase
	end
endmodule

//--- regFile.sv
// Register file with 2 reads and 1 write. r0 reads zero and a same-cycle write is seen by reads
`timescale 1ns/1ps
`include "mipsCore_settings.svh"

module regFile (
	input  logic                   sysclk,
	input  logic                   reset,
	input  logic [4:0]             readAddrA,
	input  logic [4:0]             readAddrB,
	input  logic [4:0]             writeAddr,
	input  logic                   writeEn,
	input  logic [`DATA_WIDTH-1:0] writeData,
	output logic [`DATA_WIDTH-1:0] readDataA,
	output logic [`DATA_WIDTH-1:0] readDataB
);
	logic [`DATA_WIDTH-1:0] regs [`REG_COUNT];

	// Registers start at zero so early reads are defined
	always_ff @(posedge sysclk or negedge reset) begin
		if (!reset) begin
			for (int i = 0; i < `REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (writeEn && writeAddr != 5'd0) begin
			regs[writeAddr] <= writeData;
		end
	end

	// WB writes in the same cycle that ID reads
	always_comb begin
		if (readAddrA == 5'd0) begin
			readDataA = '0;
		end else if (writeEn && writeAddr == readAddrA) begin
			readDataA = writeData;
		end else begin
			readDataA = regs[readAddrA];
		end
		if (readAddrB == 5'd0) begin
			readDataB = '0;
		end else if (writeEn && writeAddr == readAddrB) begin
			readDataB = writeData;
		end else begin
			readDataB = regs[readAddrB];
		end
	end
endmodule

//--- pipelineRegisters.sv
// Stage registers of the five-stage core. Flush beats hold and hold beats the clock edge
`timescale 1ns/1ps
`include "mipsCore_settings.svh"

module ifIdRegister (
	input  logic                   sysclk,
	input  logic                   reset,
	input  logic                   hold,
	input  logic                   flush,
	input  logic [`DATA_WIDTH-1:0] pcIn,
	input  isaPkg::instrWordT      instrIn,
	output logic [`DATA_WIDTH-1:0] pcOut,
	output isaPkg::instrWordT      instrOut
);
	// An all-zero word decodes as a no-op
	always_ff @(posedge sysclk or negedge reset) begin
		if (!reset) begin
			instrOut <= '0;
		end else if (flush) begin
			instrOut <= '0;
		end else if (!hold) begin
			instrOut <= instrIn;
		end
	end

	always_ff @(posedge sysclk) begin
		if (!hold) begin
			pcOut <= pcIn;
		end
	end
endmodule

module idExRegister (
	input  logic                   sysclk,
	input  logic                   reset,
	input  logic                   hold,
	input  logic                   flush,
	input  pipePkg::exCtrlT        exCtrlIn,
	input  pipePkg::memCtrlT       memCtrlIn,
	input  pipePkg::wbCtrlT        wbCtrlIn,
	input  logic [4:0]             rsIn,
	input  logic [4:0]             rtIn,
	input  logic [4:0]             rdIn,
	input  logic [`DATA_WIDTH-1:0] dataAIn,
	input  logic [`DATA_WIDTH-1:0] dataBIn,
	input  logic [`DATA_WIDTH-1:0] immIn,
	input  logic [`DATA_WIDTH-1:0] pcIn,
	output pipePkg::exCtrlT        exCtrlOut,
	output pipePkg::memCtrlT       memCtrlOut,
	output pipePkg::wbCtrlT        wbCtrlOut,
	output logic [4:0]             rsOut,
	output logic [4:0]             rtOut,
	output logic [4:0]             rdOut,
	output logic [`DATA_WIDTH-1:0] dataAOut,
	output logic [`DATA_WIDTH-1:0] dataBOut,
	output logic [`DATA_WIDTH-1:0] immOut,
	output logic [`DATA_WIDTH-1:0] pcOut
);
	// Bundles split by stage, zeroed for a bubble
	always_ff @(posedge sysclk or negedge reset) begin
		if (!reset) begin
			exCtrlOut <= '0;
			memCtrlOut <= '0;
			wbCtrlOut <= '0;
			rsOut <= '0;
			rtOut <= '0;
			rdOut <= '0;
		end else if (flush) begin
			exCtrlOut <= '0;
			memCtrlOut <= '0;
			wbCtrlOut <= '0;
		end else if (!hold) begin
			exCtrlOut <= exCtrlIn;
			memCtrlOut <= memCtrlIn;
			wbCtrlOut <= wbCtrlIn;
			rsOut <= rsIn;
			rtOut <= rtIn;
			rdOut <= rdIn;
		end
	end

	always_ff @(posedge sysclk) begin
		if (!hold) begin
			dataAOut <= dataAIn;
			dataBOut <= dataBIn;
			immOut <= immIn;
			pcOut <= pcIn;
		end
	end
endmodule

module exMemRegister (
	input  logic                   sysclk,
	input  logic                   reset,
	input  logic                   hold,
	input  pipePkg::memCtrlT       memCtrlIn,
	input  pipePkg::wbCtrlT        wbCtrlIn,
	input  logic [`DATA_WIDTH-1:0] aluResultIn,
	input  logic [`DATA_WIDTH-1:0] storeDataIn,
	input  logic [4:0]             destIn,
	output pipePkg::memCtrlT       memCtrlOut,
	output pipePkg::wbCtrlT        wbCtrlOut,
	output logic [`DATA_WIDTH-1:0] aluResultOut,
	output logic [`DATA_WIDTH-1:0] storeDataOut,
	output logic [4:0]             destOut
);
	always_ff @(posedge sysclk or negedge reset) begin
		if (!reset) begin
			memCtrlOut <= '0;
			wbCtrlOut <= '0;
			destOut <= '0;
		end else if (!hold) begin
			memCtrlOut <= memCtrlIn;
			wbCtrlOut <= wbCtrlIn;
			destOut <= destIn;
		end
	end

	// Address and store data stay put while the bus waits
	always_ff @(posedge sysclk) begin
		if (!hold) begin
			aluResultOut <= aluResultIn;
			storeDataOut <= storeDataIn;
		end
	end
endmodule

module memWbRegister (
	input  logic                   sysclk,
	input  logic                   reset,
	input  logic                   hold,
	input  pipePkg::wbCtrlT        wbCtrlIn,
	input  logic [`DATA_WIDTH-1:0] aluResultIn,
	input  logic [`DATA_WIDTH-1:0] readDataIn,
	input  logic [4:0]             destIn,
	output pipePkg::wbCtrlT        wbCtrlOut,
	output logic [`DATA_WIDTH-1:0] aluResultOut,
	output logic [`DATA_WIDTH-1:0] readDataOut,
	output logic [4:0]             destOut
);
	always_ff @(posedge sysclk or negedge reset) begin
		if (!reset) begin
			wbCtrlOut <= '0;
			destOut <= '0;
		end else if (!hold) begin
			wbCtrlOut <= wbCtrlIn;
			destOut <= destIn;
		end
	end

	always_ff @(posedge sysclk) begin
		if (!hold) begin
			aluResultOut <= aluResultIn;
			readDataOut <= readDataIn;
		end
	end
endmodule

//--- pipePkg.sv
// Control bundles passed between stages. An all-zero bundle is a bubble in every stage
package pipePkg;

	typedef enum logic [2:0] {
		aluAdd  = 3'd0,
		aluSub  = 3'd1,
		aluAnd  = 3'd2,
		aluOr   = 3'd3,
		aluSlt  = 3'd4,
		aluPass = 3'd5
	} aluOpT;

	// Used in EX
	typedef struct packed {
		aluOpT aluOp;
		logic  immSel;
		logic  destRd;
		logic  branch;
	} exCtrlT;

	// Used in MEM
	typedef struct packed {
		logic memRead;
		logic memWrite;
	} memCtrlT;

	// Used in WB
	typedef struct packed {
		logic regWrite;
		logic memToReg;
	} wbCtrlT;

endpackage

//--- isaPkg.sv
// Encodings of the supported MIPS subset only. Other opcodes and function codes decode as no-ops
package isaPkg;

	// Primary opcodes
	typedef enum logic [5:0] {
		opRType = 6'h00,
		opBeq   = 6'h04,
		opAddiu = 6'h09,
		opLw    = 6'h23,
		opSw    = 6'h2b
	} opcodeT;

	// R-type function codes
	typedef enum logic [5:0] {
		fnAddu = 6'h21,
		fnSubu = 6'h23,
		fnAnd  = 6'h24,
		fnOr   = 6'h25,
		fnSlt  = 6'h2a
	} functT;

	typedef struct packed {
		opcodeT     opcode;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] shamt;
		functT      funct;
	} rTypeT;

	typedef struct packed {
		opcodeT      opcode;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [15:0] imm;
	} iTypeT;

	// Same 32 bits, read as R-type or I-type
	typedef union packed {
		rTypeT r;
		iTypeT i;
	} instrWordT;

endpackage

//--- mipsCore_settings.svh
// Core sizes for the MIPS subset. The data bus takes word addresses and the PC starts at zero
`ifndef MIPS_CORE_SETTINGS_SVH
`define MIPS_CORE_SETTINGS_SVH

// Datapath word
`define DATA_WIDTH 32

// Architectural registers, addressed by 5-bit specifiers
`define REG_COUNT 32

// First fetch address after reset
`define RESET_PC 32'h0000_0000

// Word address bits on the data bus
`define DBUS_ADDR_WIDTH 10

`endif
